// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - verilog/isa_pkg.sv
  - verilog/bp_pkg.sv
  - verilog/bp_ifaces.sv
  - verilog/branch_decode.sv
  - verilog/predict_tables.sv
  - verilog/resolve_handshake.sv
  - verilog/bp_top.sv
  - target: test
    files:
      - test/bp_chk.sv
      - test/bp_tb.sv

// ==== src.f ====
verilog/isa_pkg.sv
verilog/bp_pkg.sv
verilog/bp_ifaces.sv
verilog/branch_decode.sv
verilog/predict_tables.sv
verilog/resolve_handshake.sv
verilog/bp_top.sv
test/bp_chk.sv
test/bp_tb.sv

// ==== test/bp_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_chk (
  input wire logic                         clock,
  input wire logic                         reset,
  input wire logic                         res_req,
  input wire logic                         res_ack,
  input wire logic                         redirect_valid,
  input wire logic [bp_pkg::NUM_SLOTS-1:0] pred_valid,
  input wire logic [bp_pkg::NUM_SLOTS-1:0] pred_branch,
  input wire logic [bp_pkg::NUM_SLOTS-1:0] pred_taken
);

  // ack is registered, so it answers the req seen one edge earlier
  ack_rise: assert property (@(posedge clock) disable iff (reset)
    $rose(res_ack) |-> $past(res_req))
    else $error("res_ack rose while res_req was low");

  ack_fall: assert property (@(posedge clock) disable iff (reset)
    $fell(res_ack) |-> !$past(res_req))
    else $error("res_ack fell while res_req was still high");

  redirect_single: assert property (@(posedge clock) disable iff (reset)
    redirect_valid |=> !redirect_valid)
    else $error("redirect_valid held for two cycles");

  // first edge out of reset
  quiet_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !res_ack && !redirect_valid && (pred_valid == '0) &&
                     (pred_branch == '0) && (pred_taken == '0))
    else $error("outputs active in the cycle after reset");

endmodule

`default_nettype wire

// ==== test/bp_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_tb;

  logic                                           clock = 1'b0;
  logic                                           reset;
  logic [bp_pkg::NUM_SLOTS-1:0]                   fetch_valid;
  logic [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0] fetch_pc;
  logic [bp_pkg::NUM_SLOTS-1:0][31:0]             fetch_inst;
  logic                                           res_req;
  logic                                           res_ack;
  logic                                           res_cond;
  logic                                           res_taken;
  logic                                           res_mispredict;
  logic [bp_pkg::PC_W-1:0]                        res_pc;
  logic [bp_pkg::PC_W-1:0]                        res_target;
  logic [bp_pkg::NUM_SLOTS-1:0]                   pred_valid;
  logic [bp_pkg::NUM_SLOTS-1:0]                   pred_branch;
  logic [bp_pkg::NUM_SLOTS-1:0]                   pred_taken;
  logic [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0] pred_npc;
  logic                                           redirect_valid;
  logic [bp_pkg::PC_W-1:0]                        redirect_pc;

  int          m_ctr [bp_pkg::NUM_ENTRIES];  // 0 strong_nt up to 3 strong_t
  logic [63:0] m_tgt [bp_pkg::NUM_ENTRIES];
  logic [1:0]       s1_valid;  // model decode stage
  logic [1:0][63:0] s1_pc;
  logic [1:0][31:0] s1_inst;
  logic [1:0]       e_valid;   // expected outputs
  logic [1:0]       e_branch;
  logic [1:0]       e_taken;
  logic [1:0][63:0] e_npc;
  logic             redir_exp = 1'b0;
  logic [63:0]      redir_pc_exp;
  logic [31:0]      rng = 32'ha058;
  int               pass_cnt = 0;
  int               fail_cnt = 0;
  int               ack_limit = 16;

  bp_top u_bp_top (.*);

  bind bp_top bp_chk u_bp_chk (
    .clock (clock), .reset (reset), .res_req (res_req), .res_ack (res_ack),
    .redirect_valid (redirect_valid), .pred_valid (pred_valid),
    .pred_branch (pred_branch), .pred_taken (pred_taken)
  );

  always #10 clock = ~clock;

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;  // xorshift32
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // returns {cond, uncond}
  function automatic logic [1:0] slot_class(input logic valid, input logic [31:0] inst);
    logic [1:0] cls;
    cls = 2'b00;
    if (valid) begin
      case (inst[31:26])
        isa_pkg::blbc, isa_pkg::beq, isa_pkg::blt, isa_pkg::ble,
        isa_pkg::blbs, isa_pkg::bne, isa_pkg::bge, isa_pkg::bgt: cls = 2'b10;
        isa_pkg::br, isa_pkg::bsr, isa_pkg::jsr_grp: cls = 2'b01;
        default: cls = 2'b00;
      endcase
    end
    return cls;
  endfunction

  function automatic logic model_taken(input logic [1:0] cls, input logic [63:0] pc);
    return cls[0] || (cls[1] && (m_ctr[pc[7:2]] >= 2));
  endfunction

  // eight indices with two pcs 256 bytes apart on each
  function automatic logic [63:0] pool_pc(input logic [31:0] r);
    return 64'h1000 + {r[3], 3'b000, r[2:0], 2'b00};
  endfunction

  function automatic logic [31:0] rand_inst(input logic [31:0] r);
    logic [5:0] op;
    case (r[1:0])
      2'd0:    op = {3'b111, r[28:26]};  // conditional group
      2'd1:    op = r[2] ? isa_pkg::jsr_grp : {3'b110, r[27], 2'b00};  // br or bsr
      default: op = r[31:26];  // mostly non-branch
    endcase
    return {op, r[25:0]};
  endfunction

  // two register stages reading the tables before any same-edge write
  always @(posedge clock) begin
    for (int i = 0; i < 2; i++) begin
      e_branch[i] <= !reset && (slot_class(s1_valid[i], s1_inst[i]) != 2'b00);
      e_taken[i]  <= !reset && model_taken(slot_class(s1_valid[i], s1_inst[i]), s1_pc[i]);
      e_npc[i]    <= model_taken(slot_class(s1_valid[i], s1_inst[i]), s1_pc[i]) ?
                     m_tgt[s1_pc[i][7:2]] : s1_pc[i] + 64'd4;
    end
    e_valid  <= reset ? 2'b00 : s1_valid;
    s1_valid <= reset ? 2'b00 : fetch_valid;
    s1_pc    <= fetch_pc;
    s1_inst  <= fetch_inst;
  end

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) pass_cnt++;
    else begin
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) pass_cnt++;
    else begin
      $display("%0t ns: %s", $time, what);
      fail_cnt++;
    end
  endtask

  task automatic compare_outputs();
    for (int i = 0; i < 2; i++) begin
      check_eq($sformatf("pred_valid[%0d]", i), e_valid[i], pred_valid[i]);
      check_eq($sformatf("pred_branch[%0d]", i), e_branch[i], pred_branch[i]);
      check_eq($sformatf("pred_taken[%0d]", i), e_taken[i], pred_taken[i]);
      if (e_valid[i]) check_eq($sformatf("pred_npc[%0d]", i), e_npc[i], pred_npc[i]);
    end
    check_eq("redirect_valid", redir_exp, redirect_valid);
    if (redir_exp) check_eq("redirect_pc", redir_pc_exp, redirect_pc);
    redir_exp = 1'b0;  // one cycle only
  endtask

  task automatic tick();
    @(negedge clock);
    compare_outputs();
  endtask

  task automatic rand_fetch();
    fetch_valid = next_rand();
    for (int i = 0; i < 2; i++) begin
      fetch_pc[i]   = pool_pc(next_rand());
      fetch_inst[i] = rand_inst(next_rand());
    end
  endtask

  // one four-phase transfer with req held for hold extra cycles after ack
  task automatic resolve(input logic [63:0] pc, input logic cond, input logic taken,
                         input logic [63:0] target, input logic misp, input int hold);
    int waited;
    {res_pc, res_cond, res_taken, res_target, res_mispredict} = {pc, cond, taken, target, misp};
    res_req = 1'b1;
    waited  = 0;
    do begin
      @(negedge clock);
      waited++;
      if (res_ack) begin
        redir_exp    = misp;  // redirect shows with the ack
        redir_pc_exp = taken ? target : pc + 64'd4;
      end
      compare_outputs();
    end while (!res_ack && waited < ack_limit);
    check_true(res_ack, "res_ack did not rise after res_req was raised");
    check_eq("res_ack rise latency", 2, waited);
    if (cond && taken && m_ctr[pc[7:2]] < 3) m_ctr[pc[7:2]]++;
    if (cond && !taken && m_ctr[pc[7:2]] > 0) m_ctr[pc[7:2]]--;
    if (taken) m_tgt[pc[7:2]] = target;
    repeat (hold) begin
      tick();
      check_eq("res_ack", 1, res_ack);
    end
    res_req = 1'b0;
    waited  = 0;
    do begin
      tick();
      waited++;
    end while (res_ack && waited < ack_limit);
    check_true(!res_ack, "res_ack stayed high after res_req was dropped");
  endtask

  // single conditional or unconditional branch in slot 0
  task automatic probe(input logic [63:0] pc, input logic [5:0] op, input logic taken,
                       input logic [63:0] npc);
    fetch_valid   = 2'b01;
    fetch_pc[0]   = pc;
    fetch_inst[0] = {op, 26'h0};
    tick();
    fetch_valid = 2'b00;
    tick();
    check_eq("pred_taken[0]", taken, pred_taken[0]);
    check_eq("pred_npc[0]", npc, pred_npc[0]);
  endtask

  task automatic end_test(input string name, input int fails_before);
    $display("test %-14s %s", name, (fail_cnt == fails_before) ? "ok" : "FAILED");
  endtask

  initial begin
    int          f0;
    logic [31:0] r;
    reset       = 1'b1;
    fetch_valid = '0;
    fetch_pc    = '0;
    fetch_inst  = '0;
    res_req     = 1'b0;
    {res_pc, res_cond, res_taken, res_target, res_mispredict} = '0;
    for (int e = 0; e < bp_pkg::NUM_ENTRIES; e++) begin
      m_ctr[e] = 1;  // weak_nt
      m_tgt[e] = '0;
    end
    repeat (2) @(negedge clock);
    reset = 1'b0;

    f0 = fail_cnt;
    repeat (3) tick();
    check_eq("res_ack", 0, res_ack);
    probe(64'h1234_5678, isa_pkg::beq, 1'b0, 64'h1234_567c);
    probe(64'hffff_0000_0000_00fc, isa_pkg::blbs, 1'b0, 64'hffff_0000_0000_0100);
    end_test("reset_quiet", f0);

    f0 = fail_cnt;
    repeat (200) begin
      rand_fetch();
      tick();
    end
    end_test("random_fetch", f0);

    f0 = fail_cnt;  // counter walk at index 16
    for (int n = 0; n < 3; n++) begin
      resolve(64'h2040, 1'b1, 1'b1, 64'h9000 + n * 256, 1'b0, 0);
      probe(64'h2040, isa_pkg::beq, 1'b1, 64'h9000 + n * 256);
    end
    for (int n = 0; n < 4; n++) begin
      resolve(64'h2040, 1'b1, 1'b0, 64'h0, 1'b0, 0);
      probe(64'h2040, isa_pkg::bne, n == 0, (n == 0) ? 64'h9200 : 64'h2044);
    end
    resolve(64'h2040, 1'b1, 1'b1, 64'h9300, 1'b0, 0);
    probe(64'h2040, isa_pkg::bgt, 1'b0, 64'h2044);  // strong_nt -> weak_nt only
    end_test("counter_walk", f0);

    f0 = fail_cnt;  // index 32
    resolve(64'h2080, 1'b0, 1'b1, 64'ha000, 1'b0, 0);
    probe(64'h2080, isa_pkg::br, 1'b1, 64'ha000);
    probe(64'h2080, isa_pkg::beq, 1'b0, 64'h2084);
    repeat (2) resolve(64'h2080, 1'b1, 1'b0, 64'h0, 1'b0, 0);
    probe(64'h2080, isa_pkg::jsr_grp, 1'b1, 64'ha000);
    probe(64'h2080, isa_pkg::bsr, 1'b1, 64'ha000);
    end_test("uncond", f0);

    f0 = fail_cnt;  // index 48 where a repeated strobe would keep predicting taken
    resolve(64'h20c0, 1'b1, 1'b1, 64'hb000, 1'b0, 12);
    probe(64'h20c0, isa_pkg::blt, 1'b1, 64'hb000);
    resolve(64'h20c0, 1'b1, 1'b0, 64'h0, 1'b0, 0);
    probe(64'h20c0, isa_pkg::bge, 1'b0, 64'h20c4);
    resolve(64'h20c0, 1'b1, 1'b1, 64'hb100, 1'b0, 9);
    probe(64'h20c0, isa_pkg::blt, 1'b1, 64'hb100);
    resolve(64'h20c0, 1'b1, 1'b0, 64'h0, 1'b0, 0);
    probe(64'h20c0, isa_pkg::bge, 1'b0, 64'h20c4);
    end_test("handshake", f0);

    f0 = fail_cnt;
    repeat (40) begin
      rand_fetch();
      r = next_rand();
      resolve(pool_pc(r), r[4], r[5], 64'h8000 + {r[15:8], 2'b00}, r[6], r[9:8]);
      rand_fetch();
      repeat (2) tick();
    end
    end_test("redirect", f0);

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/bp_ifaces.sv ====
`timescale 1ns/100ps
`default_nettype none

// decoded fetch bundle, one entry per slot
interface slot_if;

  logic [bp_pkg::NUM_SLOTS-1:0]                   valid;
  logic [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0] pc;
  logic [bp_pkg::NUM_SLOTS-1:0]                   is_cond;    // conditional branch
  logic [bp_pkg::NUM_SLOTS-1:0]                   is_uncond;  // br, bsr, jsr group

  modport decode (
    output valid, pc, is_cond, is_uncond
  );

  modport lookup (
    input valid, pc, is_cond, is_uncond
  );

endinterface

// one resolved branch, presented for a single cycle
interface upd_if;

  logic                    upd_valid;  // one-cycle strobe
  logic [bp_pkg::PC_W-1:0] upd_pc;
  logic                    upd_cond;
  logic                    upd_taken;
  logic [bp_pkg::PC_W-1:0] upd_target;
  logic                    upd_mispredict;

  modport source (
    output upd_valid, upd_pc, upd_cond, upd_taken, upd_target, upd_mispredict
  );

  modport sink (
    input upd_valid, upd_pc, upd_cond, upd_taken, upd_target, upd_mispredict
  );

endinterface

`default_nettype wire

// ==== verilog/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

  localparam int NUM_SLOTS = 2;  // fetch width

  // table index is pc[IDX_BITS+1:2]
  localparam int IDX_BITS    = 6;
  localparam int NUM_ENTRIES = 1 << IDX_BITS;

  localparam int PC_W = 64;

  // fall-through step, already at pc width
  localparam logic [PC_W-1:0] INST_BYTES = PC_W'(4);

  // 2-bit saturating counter, upper half predicts taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_e;

  localparam ctr_e CTR_RESET = weak_nt;
  localparam logic [PC_W-1:0] TGT_RESET = '0;

endpackage

`default_nettype wire

// ==== verilog/bp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_top (
  input  wire logic                                               clock,
  input  wire logic                                               reset,
  input  wire logic [bp_pkg::NUM_SLOTS-1:0]                       fetch_valid,
  input  wire logic [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0]     fetch_pc,
  input  wire logic [bp_pkg::NUM_SLOTS-1:0][isa_pkg::INST_W-1:0]  fetch_inst,
  input  wire logic                                               res_req,
  output logic                                                    res_ack,
  input  wire logic [bp_pkg::PC_W-1:0]                            res_pc,
  input  wire logic                                               res_cond,
  input  wire logic                                               res_taken,
  input  wire logic [bp_pkg::PC_W-1:0]                            res_target,
  input  wire logic                                               res_mispredict,
  output logic      [bp_pkg::NUM_SLOTS-1:0]                       pred_valid,
  output logic      [bp_pkg::NUM_SLOTS-1:0]                       pred_branch,
  output logic      [bp_pkg::NUM_SLOTS-1:0]                       pred_taken,
  output logic      [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0]     pred_npc,
  output logic                                                    redirect_valid,
  output logic      [bp_pkg::PC_W-1:0]                            redirect_pc
);

  slot_if slot_bus ();  // decode -> lookup
  upd_if  upd_bus ();   // resolved branch -> tables

  branch_decode u_branch_decode (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_inst  (fetch_inst),
    .slot        (slot_bus.decode)
  );

  resolve_handshake u_resolve_handshake (
    .clock          (clock),
    .reset          (reset),
    .res_req        (res_req),
    .res_ack        (res_ack),
    .res_pc         (res_pc),
    .res_cond       (res_cond),
    .res_taken      (res_taken),
    .res_target     (res_target),
    .res_mispredict (res_mispredict),
    .upd            (upd_bus.source)
  );

  predict_tables u_predict_tables (
    .clock          (clock),
    .reset          (reset),
    .slot           (slot_bus.lookup),
    .upd            (upd_bus.sink),
    .pred_valid     (pred_valid),
    .pred_branch    (pred_branch),
    .pred_taken     (pred_taken),
    .pred_npc       (pred_npc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

// ==== verilog/branch_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_decode (
  input  wire logic                                           clock,
  input  wire logic                                           reset,
  input  wire logic [bp_pkg::NUM_SLOTS-1:0]                   fetch_valid,
  input  wire logic [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0] fetch_pc,
  input  wire logic [bp_pkg::NUM_SLOTS-1:0][isa_pkg::INST_W-1:0] fetch_inst,
  slot_if.decode                                              slot
);

  isa_pkg::opcode_e             op [bp_pkg::NUM_SLOTS];
  logic [bp_pkg::NUM_SLOTS-1:0] cond_d;
  logic [bp_pkg::NUM_SLOTS-1:0] uncond_d;

  // classify each slot by its major opcode
  always_comb begin
    for (int i = 0; i < bp_pkg::NUM_SLOTS; i++) begin
      op[i] = isa_pkg::opcode_e'(fetch_inst[i][isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);
      cond_d[i]   = 1'b0;
      uncond_d[i] = 1'b0;
      if (fetch_valid[i]) begin
        case (op[i])
          isa_pkg::blbc, isa_pkg::beq, isa_pkg::blt, isa_pkg::ble,
          isa_pkg::blbs, isa_pkg::bne, isa_pkg::bge, isa_pkg::bgt: begin
            cond_d[i] = 1'b1;
          end
          isa_pkg::br, isa_pkg::bsr, isa_pkg::jsr_grp: begin
            uncond_d[i] = 1'b1;
          end
          default: begin
            // not a branch
          end
        endcase
      end
    end
  end

  // decode register, control part
  always_ff @(posedge clock) begin
    if (reset) begin
      slot.valid     <= '0;
      slot.is_cond   <= '0;
      slot.is_uncond <= '0;
    end else begin
      slot.valid     <= fetch_valid;
      slot.is_cond   <= cond_d;
      slot.is_uncond <= uncond_d;
    end
  end

  always_ff @(posedge clock) begin
    slot.pc <= fetch_pc;  // payload, follows valid
  end

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int INST_W = 32;

  // major opcode field, top six bits of every instruction word
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;

  // only the major opcodes the predictor cares about
  typedef enum logic [5:0] {
    other   = 6'h00,  // stands for any non-branch opcode
    jsr_grp = 6'h1a,  // jmp, jsr, ret, jsr_coroutine
    br      = 6'h30,
    bsr     = 6'h34,
    blbc    = 6'h38,
    beq     = 6'h39,
    blt     = 6'h3a,
    ble     = 6'h3b,
    blbs    = 6'h3c,
    bne     = 6'h3d,
    bge     = 6'h3e,
    bgt     = 6'h3f
  } opcode_e;

endpackage

`default_nettype wire

// ==== verilog/predict_tables.sv ====
`timescale 1ns/100ps
`default_nettype none

module predict_tables (
  input  wire logic                                            clock,
  input  wire logic                                            reset,
  slot_if.lookup                                               slot,
  upd_if.sink                                                  upd,
  output logic      [bp_pkg::NUM_SLOTS-1:0]                    pred_valid,
  output logic      [bp_pkg::NUM_SLOTS-1:0]                    pred_branch,
  output logic      [bp_pkg::NUM_SLOTS-1:0]                    pred_taken,
  output logic      [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0]  pred_npc,
  output logic                                                 redirect_valid,
  output logic      [bp_pkg::PC_W-1:0]                         redirect_pc
);

  bp_pkg::ctr_e            ctr_tbl [bp_pkg::NUM_ENTRIES];
  logic [bp_pkg::PC_W-1:0] tgt_tbl [bp_pkg::NUM_ENTRIES];

  logic [bp_pkg::IDX_BITS-1:0]                    rd_idx [bp_pkg::NUM_SLOTS];
  logic [bp_pkg::NUM_SLOTS-1:0]                   taken_d;
  logic [bp_pkg::NUM_SLOTS-1:0][bp_pkg::PC_W-1:0] npc_d;
  logic [bp_pkg::IDX_BITS-1:0]                    wr_idx;

  // one saturating step toward the resolved direction
  function automatic bp_pkg::ctr_e ctr_step(input bp_pkg::ctr_e ctr, input logic taken);
    bp_pkg::ctr_e nxt;
    case (ctr)
      bp_pkg::strong_nt: nxt = taken ? bp_pkg::weak_nt  : bp_pkg::strong_nt;
      bp_pkg::weak_nt:   nxt = taken ? bp_pkg::weak_t   : bp_pkg::strong_nt;
      bp_pkg::weak_t:    nxt = taken ? bp_pkg::strong_t : bp_pkg::weak_nt;
      default:           nxt = taken ? bp_pkg::strong_t : bp_pkg::weak_t;
    endcase
    return nxt;
  endfunction

  // lookup reads the tables as they stand, same-edge writes are not seen
  always_comb begin
    for (int i = 0; i < bp_pkg::NUM_SLOTS; i++) begin
      rd_idx[i]  = slot.pc[i][bp_pkg::IDX_BITS+1:2];
      taken_d[i] = slot.is_uncond[i] ||
                   (slot.is_cond[i] && (ctr_tbl[rd_idx[i]] inside {bp_pkg::weak_t,
                                                                   bp_pkg::strong_t}));
      npc_d[i]   = taken_d[i] ? tgt_tbl[rd_idx[i]] : slot.pc[i] + bp_pkg::INST_BYTES;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pred_valid  <= '0;
      pred_branch <= '0;
      pred_taken  <= '0;
    end else begin
      pred_valid  <= slot.valid;
      pred_branch <= slot.is_cond | slot.is_uncond;
      pred_taken  <= taken_d;
    end
  end

  always_ff @(posedge clock) begin
    pred_npc <= npc_d;
  end

  assign wr_idx = upd.upd_pc[bp_pkg::IDX_BITS+1:2];

  // training, one resolved branch per strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int e = 0; e < bp_pkg::NUM_ENTRIES; e++) begin
        ctr_tbl[e] <= bp_pkg::CTR_RESET;
        tgt_tbl[e] <= bp_pkg::TGT_RESET;
      end
    end else if (upd.upd_valid) begin
      if (upd.upd_cond) begin
        ctr_tbl[wr_idx] <= ctr_step(ctr_tbl[wr_idx], upd.upd_taken);
      end
      if (upd.upd_taken) begin
        tgt_tbl[wr_idx] <= upd.upd_target;  // unconditional ones too
      end
    end
  end

  // redirect lasts one cycle, the strobe already does
  always_ff @(posedge clock) begin
    if (reset) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= upd.upd_valid && upd.upd_mispredict;
    end
  end

  always_ff @(posedge clock) begin
    if (upd.upd_valid) begin
      redirect_pc <= upd.upd_taken ? upd.upd_target : upd.upd_pc + bp_pkg::INST_BYTES;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/resolve_handshake.sv ====
`timescale 1ns/100ps
`default_nettype none

module resolve_handshake (
  input  wire logic                    clock,
  input  wire logic                    reset,
  input  wire logic                    res_req,
  output logic                         res_ack,
  input  wire logic [bp_pkg::PC_W-1:0] res_pc,
  input  wire logic                    res_cond,
  input  wire logic                    res_taken,
  input  wire logic [bp_pkg::PC_W-1:0] res_target,
  input  wire logic                    res_mispredict,
  upd_if.source                        upd
);

  typedef enum logic {
    idle,
    acked
  } hs_state_e;

  hs_state_e state;
  logic      start;

  // new request, ack still low from the previous one
  assign start = (state == idle) && res_req && !res_ack;

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= idle;
      res_ack       <= 1'b0;
      upd.upd_valid <= 1'b0;
    end else begin
      upd.upd_valid <= start;  // exactly one strobe per request
      case (state)
        idle: begin
          res_ack <= 1'b0;
          if (start) begin
            state <= acked;
          end
        end
        acked: begin
          res_ack <= res_req;  // rises next edge, falls once req drops
          if (!res_req) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // payload held in the update register until the next request
  always_ff @(posedge clock) begin
    if (start) begin
      upd.upd_pc         <= res_pc;
      upd.upd_cond       <= res_cond;
      upd.upd_taken      <= res_taken;
      upd.upd_target     <= res_target;
      upd.upd_mispredict <= res_mispredict;
    end
  end

endmodule

`default_nettype wire
